//--- rv_decode.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_ctrl_pkg.sv
id_stage/rv_decoder.sv
id_stage/rv_bypass_ctrl.sv
id_stage/rv_id_stage.sv
design/rv_regfile.sv
design/rv_id_top.sv
verif/tb_clkgen.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line

set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_top -Mdir obj_dir -f rv_decode.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_top 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

//--- verif/tb_top.sv
`timescale 1ns/1ps

module tb_top;

import rv_isa_pkg::*;
import rv_ctrl_pkg::*;

localparam int          RUN_CYCLES     = 3000;
localparam int          TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 3;
localparam logic [31:0] LFSR_SEED      = 32'h477a_22f0;
localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

logic        clk;
logic        rst_n;
word_t       instr;
word_t       pc;
logic        hazard;
logic        ex_we;
reg_addr_t   ex_rd;
word_t       ex_data;
logic        mem_we;
reg_addr_t   mem_rd;
word_t       mem_data;
logic        wb_we;
reg_addr_t   wb_waddr;
word_t       wb_data;
logic        load_use;
alu_op_e     alu_op;
word_t       alu_a;
word_t       alu_b;
logic        rf_we;
reg_addr_t   rf_waddr;
logic        mem_rd_flag;
logic        mem_wr_flag;
mem_size_e   mem_size;
logic        mem_sign_ext;
word_t       store_data;
word_t       br_a;
word_t       br_b;
bypass_e     bypass_a;
bypass_e     bypass_b;
logic [31:0] error_count;
logic [31:0] check_count;
logic [31:0] lfsr_state;
int          cycle_count = 0;

tb_clkgen #(.RESET_CYCLES(16)) u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
);

rv_id_top dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .instr_i        (instr),
    .pc_i           (pc),
    .hazard_i       (hazard),
    .ex_we_i        (ex_we),
    .ex_rd_i        (ex_rd),
    .ex_data_i      (ex_data),
    .mem_we_i       (mem_we),
    .mem_rd_i       (mem_rd),
    .mem_data_i     (mem_data),
    .wb_we_i        (wb_we),
    .wb_waddr_i     (wb_waddr),
    .wb_data_i      (wb_data),
    .load_use_o     (load_use),
    .alu_op_o       (alu_op),
    .alu_a_o        (alu_a),
    .alu_b_o        (alu_b),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .mem_rd_o       (mem_rd_flag),
    .mem_wr_o       (mem_wr_flag),
    .mem_size_o     (mem_size),
    .mem_sign_ext_o (mem_sign_ext),
    .store_data_o   (store_data),
    .br_a_o         (br_a),
    .br_b_o         (br_b),
    .bypass_a_o     (bypass_a),
    .bypass_b_o     (bypass_b)
);

tb_checker u_checker (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .instr_i        (instr),
    .pc_i           (pc),
    .hazard_i       (hazard),
    .ex_we_i        (ex_we),
    .ex_rd_i        (ex_rd),
    .ex_data_i      (ex_data),
    .mem_we_i       (mem_we),
    .mem_rd_i       (mem_rd),
    .mem_data_i     (mem_data),
    .wb_we_i        (wb_we),
    .wb_waddr_i     (wb_waddr),
    .wb_data_i      (wb_data),
    .load_use_i     (load_use),
    .alu_op_i       (alu_op),
    .alu_a_i        (alu_a),
    .alu_b_i        (alu_b),
    .rf_we_i        (rf_we),
    .rf_waddr_i     (rf_waddr),
    .mem_rd_flag_i  (mem_rd_flag),
    .mem_wr_flag_i  (mem_wr_flag),
    .mem_size_i     (mem_size),
    .mem_sign_ext_i (mem_sign_ext),
    .store_data_i   (store_data),
    .br_a_i         (br_a),
    .br_b_i         (br_b),
    .bypass_a_i     (bypass_a),
    .bypass_b_i     (bypass_b),
    .error_count_o  (error_count),
    .check_count_o  (check_count)
);

function automatic logic [31:0] next_lfsr(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] draw_bits(input int nbits);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < nbits; i++) begin
        lfsr_state = next_lfsr(lfsr_state);
        bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
endfunction

// Half the draws land on x0..x7 so matches are frequent
function automatic reg_addr_t draw_reg();
    if (draw_bits(1) != 0) begin
        return reg_addr_t'(draw_bits(3));
    end
    return reg_addr_t'(draw_bits(5));
endfunction

function automatic opcode_e pick_opcode(input logic [2:0] idx);
    case (idx)
        3'd0:    return OPC_LUI;
        3'd1:    return OPC_AUIPC;
        3'd2:    return OPC_OP_IMM;
        3'd3:    return OPC_OP;
        3'd4:    return OPC_LOAD;
        3'd5:    return OPC_STORE;
        3'd6:    return OPC_BRANCH;
        default: return OPC_JAL;
    endcase
endfunction

// Random but legal RV32I encoding of one of the eight opcodes
function automatic word_t build_instr();
    opcode_e    opc;
    word_t      ins;
    logic [2:0] f3;
    logic       alt;
    opc       = pick_opcode(3'(draw_bits(3)));
    ins       = draw_bits(25) << 7;
    ins[6:0]  = opc;
    f3        = 3'(draw_bits(3));
    alt       = 1'(draw_bits(1));
    case (opc)
        OPC_OP: begin
            if (f3 != 3'b000 && f3 != 3'b101) begin
                alt = 1'b0;
            end
            ins[31:25] = {1'b0, alt, 5'b0};
        end
        OPC_OP_IMM: begin
            if (f3 == 3'b001) begin
                ins[31:25] = 7'b0;
            end else if (f3 == 3'b101) begin
                ins[31:25] = {1'b0, alt, 5'b0};
            end
        end
        OPC_LOAD: begin
            if (f3 inside {3'b011, 3'b110, 3'b111}) begin
                f3 = f3 & 3'b101;
            end
        end
        OPC_STORE: begin
            f3 = {1'b0, f3[1] & ~f3[0], f3[0]};
        end
        OPC_BRANCH: begin
            if (f3[2:1] == 2'b01) begin
                f3[1] = 1'b0;
            end
        end
        default: ;
    endcase
    if (!(opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL})) begin
        ins[14:12] = f3;
        ins[19:15] = draw_reg();
    end
    if (opc inside {OPC_OP, OPC_STORE, OPC_BRANCH}) begin
        ins[24:20] = draw_reg();
    end
    if (!(opc inside {OPC_STORE, OPC_BRANCH})) begin
        ins[11:7] = draw_reg();
    end
    return ins;
endfunction

task automatic drive_cycle();
    if (draw_bits(4) == 0) begin
        instr = NOP_INSTR;
    end else begin
        instr = build_instr();
    end
    pc       = draw_bits(30) << 2;
    hazard   = (draw_bits(3) == 0);
    ex_we    = 1'(draw_bits(1));
    ex_rd    = draw_reg();
    ex_data  = draw_bits(32);
    mem_we   = 1'(draw_bits(1));
    mem_rd   = draw_reg();
    mem_data = draw_bits(32);
    wb_we    = 1'(draw_bits(1));
    wb_waddr = draw_reg();
    wb_data  = draw_bits(32);
endtask

initial begin : stimulus
    lfsr_state = LFSR_SEED;
    instr      = NOP_INSTR;
    pc         = '0;
    hazard     = 1'b0;
    ex_we      = 1'b0;
    ex_rd      = '0;
    ex_data    = '0;
    mem_we     = 1'b0;
    mem_rd     = '0;
    mem_data   = '0;
    wb_we      = 1'b0;
    wb_waddr   = '0;
    wb_data    = '0;
    wait (rst_n === 1'b1);
    repeat (RUN_CYCLES) begin
        @(negedge clk);
        drive_cycle();
    end
    // Let the last prediction reach the compare
    repeat (2) @(posedge clk);
    @(negedge clk);
    $display("run ended after %0d cycles: %0d checks, %0d errors",
             cycle_count, check_count, error_count);
    if (error_count == 0 && check_count != 0) begin
        $display("TEST PASSED");
    end else begin
        if (check_count == 0) begin
            $display("no output was ever compared");
        end
        $display("TEST FAILED");
    end
    $finish;
end

always @(posedge clk) begin : watchdog
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
        $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end
end

endmodule

//--- verif/tb_checker.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_checker (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  rv_isa_pkg::word_t      instr_i,
    input  rv_isa_pkg::word_t      pc_i,
    input  logic                   hazard_i,
    input  logic                   ex_we_i,
    input  rv_isa_pkg::reg_addr_t  ex_rd_i,
    input  rv_isa_pkg::word_t      ex_data_i,
    input  logic                   mem_we_i,
    input  rv_isa_pkg::reg_addr_t  mem_rd_i,
    input  rv_isa_pkg::word_t      mem_data_i,
    input  logic                   wb_we_i,
    input  rv_isa_pkg::reg_addr_t  wb_waddr_i,
    input  rv_isa_pkg::word_t      wb_data_i,
    input  logic                   load_use_i,
    input  rv_ctrl_pkg::alu_op_e   alu_op_i,
    input  rv_isa_pkg::word_t      alu_a_i,
    input  rv_isa_pkg::word_t      alu_b_i,
    input  logic                   rf_we_i,
    input  rv_isa_pkg::reg_addr_t  rf_waddr_i,
    input  logic                   mem_rd_flag_i,
    input  logic                   mem_wr_flag_i,
    input  rv_ctrl_pkg::mem_size_e mem_size_i,
    input  logic                   mem_sign_ext_i,
    input  rv_isa_pkg::word_t      store_data_i,
    input  rv_isa_pkg::word_t      br_a_i,
    input  rv_isa_pkg::word_t      br_b_i,
    input  rv_ctrl_pkg::bypass_e   bypass_a_i,
    input  rv_ctrl_pkg::bypass_e   bypass_b_i,
    output logic [31:0]            error_count_o,
    output logic [31:0]            check_count_o
);

import rv_isa_pkg::*;
import rv_ctrl_pkg::*;

word_t       model_regs [`RV_NUM_REGS];
logic        pred_valid = 1'b0;
alu_op_e     exp_alu_op;
word_t       exp_alu_a;
word_t       exp_alu_b;
word_t       exp_store;
word_t       exp_br_a;
word_t       exp_br_b;
logic        exp_rf_we;
reg_addr_t   exp_rd;
logic        exp_mem_rd = 1'b0;
logic        exp_mem_wr;
mem_size_e   exp_size;
logic        exp_sext;
bypass_e     exp_byp_a;
bypass_e     exp_byp_b;
logic        chk_byp_a;
logic        chk_byp_b;
logic        chk_data_b;
logic        chk_br_a;
int unsigned errors = 0;
int unsigned checks = 0;

assign error_count_o = errors;
assign check_count_o = checks;

function automatic logic has_no_src(input logic [6:0] opc);
    return opc == OPC_LUI || opc == OPC_AUIPC;
endfunction

function automatic logic reads_rs1(input logic [6:0] opc);
    return opc inside {OPC_OP_IMM, OPC_OP, OPC_LOAD, OPC_STORE, OPC_BRANCH};
endfunction

function automatic logic reads_rs2(input logic [6:0] opc);
    return opc inside {OPC_OP, OPC_STORE, OPC_BRANCH};
endfunction

// Immediate formats from the RV32I encoding tables
function automatic word_t build_imm(input word_t ins);
    case (ins[6:0])
        OPC_LUI, OPC_AUIPC:   return ins & 32'hffff_f000;
        OPC_OP_IMM, OPC_LOAD: return word_t'($signed(ins) >>> 20);
        OPC_STORE:            return {{21{ins[31]}}, ins[30:25], ins[11:7]};
        OPC_BRANCH:           return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        OPC_JAL:              return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        default:              return '0;
    endcase
endfunction

function automatic alu_op_e model_alu_op(input word_t ins);
    logic [6:0] opc;
    logic       alt;
    opc = ins[6:0];
    alt = ins[30];
    if (opc != OPC_OP && opc != OPC_OP_IMM) begin
        return ALU_ADD;
    end
    case (ins[14:12])
        3'b000:  return (opc == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
        3'b001:  return ALU_SLL;
        3'b010:  return ALU_SLT;
        3'b011:  return ALU_SLTU;
        3'b100:  return ALU_XOR;
        3'b101:  return alt ? ALU_SRA : ALU_SRL;
        3'b110:  return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

// MEM first so that a matching EX overrides it
function automatic bypass_e fwd_source(input reg_addr_t src);
    bypass_e sel;
    sel = BYP_NONE;
    if (src != '0) begin
        if (mem_we_i && mem_rd_i == src) begin
            sel = BYP_MEM;
        end
        if (ex_we_i && ex_rd_i == src) begin
            sel = BYP_EX;
        end
    end
    return sel;
endfunction

function automatic word_t fwd_data(input bypass_e sel, input reg_addr_t raddr);
    case (sel)
        BYP_EX:  return ex_data_i;
        BYP_MEM: return mem_data_i;
        default: return model_regs[raddr];
    endcase
endfunction

task automatic compare_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] got_val);
    checks++;
    if (got_val !== exp_val) begin
        errors++;
        $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp_val, got_val);
    end
endtask

task automatic predict_stage();
    logic [6:0] opc;
    logic       no_src;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      imm;
    word_t      data_a;
    word_t      data_b;
    opc        = instr_i[6:0];
    no_src     = has_no_src(opc);
    rs1        = instr_i[19:15];
    rs2        = instr_i[24:20];
    imm        = build_imm(instr_i);
    exp_byp_a  = fwd_source(no_src ? '0 : rs1);
    exp_byp_b  = fwd_source(no_src ? '0 : rs2);
    data_a     = fwd_data(exp_byp_a, rs1);
    data_b     = fwd_data(exp_byp_b, rs2);
    exp_alu_op = model_alu_op(instr_i);
    case (opc)
        OPC_LUI:                       exp_alu_a = '0;
        OPC_AUIPC, OPC_JAL, OPC_BRANCH: exp_alu_a = pc_i;
        default:                       exp_alu_a = data_a;
    endcase
    exp_alu_b  = (opc == OPC_OP) ? data_b : imm;
    exp_br_a   = (opc == OPC_JAL) ? pc_i + 32'd4 : data_a;
    exp_br_b   = data_b;
    exp_store  = data_b;
    exp_rd     = instr_i[11:7];
    exp_rf_we  = (opc inside {OPC_LUI, OPC_AUIPC, OPC_OP_IMM, OPC_OP, OPC_LOAD, OPC_JAL}) &&
                 (instr_i != `RV_NOP);
    exp_mem_rd = (opc == OPC_LOAD);
    exp_mem_wr = (opc == OPC_STORE);
    exp_size   = mem_size_e'(instr_i[13:12]);
    exp_sext   = (opc == OPC_LOAD) && !instr_i[14];
    chk_byp_a  = reads_rs1(opc) || no_src;
    chk_byp_b  = reads_rs2(opc) || no_src;
    chk_data_b = reads_rs2(opc);
    chk_br_a   = reads_rs1(opc) || opc == OPC_JAL;
endtask

task automatic compare_outputs();
    compare_value("alu_op_o", 32'(exp_alu_op), 32'(alu_op_i));
    compare_value("alu_a_o", exp_alu_a, alu_a_i);
    compare_value("alu_b_o", exp_alu_b, alu_b_i);
    compare_value("rf_we_o", 32'(exp_rf_we), 32'(rf_we_i));
    compare_value("rf_waddr_o", 32'(exp_rd), 32'(rf_waddr_i));
    compare_value("mem_rd_o", 32'(exp_mem_rd), 32'(mem_rd_flag_i));
    compare_value("mem_wr_o", 32'(exp_mem_wr), 32'(mem_wr_flag_i));
    if (exp_mem_rd || exp_mem_wr) begin
        compare_value("mem_size_o", 32'(exp_size), 32'(mem_size_i));
        compare_value("mem_sign_ext_o", 32'(exp_sext), 32'(mem_sign_ext_i));
    end
    if (chk_byp_a) begin
        compare_value("bypass_a_o", 32'(exp_byp_a), 32'(bypass_a_i));
    end
    if (chk_byp_b) begin
        compare_value("bypass_b_o", 32'(exp_byp_b), 32'(bypass_b_i));
    end
    if (chk_data_b) begin
        compare_value("store_data_o", exp_store, store_data_i);
        compare_value("br_b_o", exp_br_b, br_b_i);
    end
    if (chk_br_a) begin
        compare_value("br_a_o", exp_br_a, br_a_i);
    end
endtask

// Issued-load record is the held expectation of the instruction in EX
task automatic check_load_use();
    logic [6:0] opc;
    reg_addr_t  src_a;
    reg_addr_t  src_b;
    logic       stall;
    opc   = instr_i[6:0];
    src_a = has_no_src(opc) ? '0 : instr_i[19:15];
    src_b = has_no_src(opc) ? '0 : instr_i[24:20];
    stall = exp_mem_rd && (exp_rd != '0) &&
            ((reads_rs1(opc) && src_a == exp_rd) || (reads_rs2(opc) && src_b == exp_rd));
    compare_value("load_use_o", 32'(stall), 32'(load_use_i));
endtask

task automatic update_regs();
    if (!rst_n_i) begin
        foreach (model_regs[i]) begin
            model_regs[i] = '0;
        end
    end else if (wb_we_i && wb_waddr_i != '0) begin
        model_regs[wb_waddr_i] = wb_data_i;
    end
endtask

// DUT outputs still hold the values of the previous edge here
always @(posedge clk_i) begin : check_edge
    if (rst_n_i) begin
        check_load_use();
        if (pred_valid) begin
            compare_outputs();
        end
    end
    if (!hazard_i) begin
        predict_stage();
    end
    if (!rst_n_i) begin
        pred_valid = 1'b0;
        exp_rf_we  = 1'b0;
        exp_mem_rd = 1'b0;
        exp_mem_wr = 1'b0;
        exp_byp_a  = BYP_NONE;
        exp_byp_b  = BYP_NONE;
    end else if (!hazard_i) begin
        pred_valid = 1'b1;
    end
    // Write lands after the read of this cycle
    update_regs();
end

endmodule

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

// 10 ns period
initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
end

// Release on a falling edge, away from the sampling edge
initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
end

endmodule

//--- design/rv_id_top.sv
`timescale 1ns/1ps

module rv_id_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  rv_isa_pkg::word_t       instr_i,
    input  rv_isa_pkg::word_t       pc_i,
    input  logic                    hazard_i,
    input  logic                    ex_we_i,
    input  rv_isa_pkg::reg_addr_t   ex_rd_i,
    input  rv_isa_pkg::word_t       ex_data_i,
    input  logic                    mem_we_i,
    input  rv_isa_pkg::reg_addr_t   mem_rd_i,
    input  rv_isa_pkg::word_t       mem_data_i,
    input  logic                    wb_we_i,
    input  rv_isa_pkg::reg_addr_t   wb_waddr_i,
    input  rv_isa_pkg::word_t       wb_data_i,
    output logic                    load_use_o,
    output rv_ctrl_pkg::alu_op_e    alu_op_o,
    output rv_isa_pkg::word_t       alu_a_o,
    output rv_isa_pkg::word_t       alu_b_o,
    output logic                    rf_we_o,
    output rv_isa_pkg::reg_addr_t   rf_waddr_o,
    output logic                    mem_rd_o,
    output logic                    mem_wr_o,
    output rv_ctrl_pkg::mem_size_e  mem_size_o,
    output logic                    mem_sign_ext_o,
    output rv_isa_pkg::word_t       store_data_o,
    output rv_isa_pkg::word_t       br_a_o,
    output rv_isa_pkg::word_t       br_b_o,
    output rv_ctrl_pkg::bypass_e    bypass_a_o,
    output rv_ctrl_pkg::bypass_e    bypass_b_o
);

import rv_isa_pkg::*;

reg_addr_t rf_raddr_a;
reg_addr_t rf_raddr_b;
word_t     rf_data_a;
word_t     rf_data_b;

rv_regfile u_regfile (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_data_a),
    .rdata_b_o (rf_data_b),
    .we_i      (wb_we_i),
    .waddr_i   (wb_waddr_i),
    .wdata_i   (wb_data_i)
);

rv_id_stage u_id_stage (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .hazard_i       (hazard_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .rf_data_a_i    (rf_data_a),
    .rf_data_b_i    (rf_data_b),
    .ex_we_i        (ex_we_i),
    .ex_rd_i        (ex_rd_i),
    .ex_data_i      (ex_data_i),
    .mem_we_i       (mem_we_i),
    .mem_rd_i       (mem_rd_i),
    .mem_data_i     (mem_data_i),
    .rf_raddr_a_o   (rf_raddr_a),
    .rf_raddr_b_o   (rf_raddr_b),
    .load_use_o     (load_use_o),
    .alu_op_o       (alu_op_o),
    .alu_a_o        (alu_a_o),
    .alu_b_o        (alu_b_o),
    .rf_we_o        (rf_we_o),
    .rf_waddr_o     (rf_waddr_o),
    .mem_rd_o       (mem_rd_o),
    .mem_wr_o       (mem_wr_o),
    .mem_size_o     (mem_size_o),
    .mem_sign_ext_o (mem_sign_ext_o),
    .store_data_o   (store_data_o),
    .br_a_o         (br_a_o),
    .br_b_o         (br_b_o),
    .bypass_a_o     (bypass_a_o),
    .bypass_b_o     (bypass_b_o)
);

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_regfile (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  rv_isa_pkg::reg_addr_t raddr_a_i,
    input  rv_isa_pkg::reg_addr_t raddr_b_i,
    output rv_isa_pkg::word_t     rdata_a_o,
    output rv_isa_pkg::word_t     rdata_b_o,
    input  logic                  we_i,
    input  rv_isa_pkg::reg_addr_t waddr_i,
    input  rv_isa_pkg::word_t     wdata_i
);

import rv_isa_pkg::*;

word_t regs [`RV_NUM_REGS];

// x0 is cleared by reset and never written
always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            regs[i] <= '0;
        end
    end else if (we_i && waddr_i != '0) begin
        regs[waddr_i] <= wdata_i;
    end
end

// Same-cycle write is not visible here
assign rdata_a_o = regs[raddr_a_i];
assign rdata_b_o = regs[raddr_b_i];

endmodule

//--- id_stage/rv_id_stage.sv
`timescale 1ns/1ps

module rv_id_stage (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    hazard_i,
    input  rv_isa_pkg::word_t       instr_i,
    input  rv_isa_pkg::word_t       pc_i,
    input  rv_isa_pkg::word_t       rf_data_a_i,
    input  rv_isa_pkg::word_t       rf_data_b_i,
    input  logic                    ex_we_i,
    input  rv_isa_pkg::reg_addr_t   ex_rd_i,
    input  rv_isa_pkg::word_t       ex_data_i,
    input  logic                    mem_we_i,
    input  rv_isa_pkg::reg_addr_t   mem_rd_i,
    input  rv_isa_pkg::word_t       mem_data_i,
    output rv_isa_pkg::reg_addr_t   rf_raddr_a_o,
    output rv_isa_pkg::reg_addr_t   rf_raddr_b_o,
    output logic                    load_use_o,
    output rv_ctrl_pkg::alu_op_e    alu_op_o,
    output rv_isa_pkg::word_t       alu_a_o,
    output rv_isa_pkg::word_t       alu_b_o,
    output logic                    rf_we_o,
    output rv_isa_pkg::reg_addr_t   rf_waddr_o,
    output logic                    mem_rd_o,
    output logic                    mem_wr_o,
    output rv_ctrl_pkg::mem_size_e  mem_size_o,
    output logic                    mem_sign_ext_o,
    output rv_isa_pkg::word_t       store_data_o,
    output rv_isa_pkg::word_t       br_a_o,
    output rv_isa_pkg::word_t       br_b_o,
    output rv_ctrl_pkg::bypass_e    bypass_a_o,
    output rv_ctrl_pkg::bypass_e    bypass_b_o
);

import rv_isa_pkg::*;
import rv_ctrl_pkg::*;

opcode_e    opcode;
reg_addr_t  rd;
word_t      imm;
alu_op_e    alu_op;
src_a_sel_e src_a_sel;
src_b_sel_e src_b_sel;
br_a_sel_e  br_a_sel;
logic       rf_we;
logic       mem_rd;
logic       mem_wr;
logic       mem_sign_ext;
mem_size_e  mem_size;
bypass_e    bypass_a;
bypass_e    bypass_b;
word_t      data_a;
word_t      data_b;
word_t      alu_a;
word_t      alu_b;
word_t      br_a;

rv_decoder u_decoder (
    .instr_i        (instr_i),
    .opcode_o       (opcode),
    .rs1_o          (rf_raddr_a_o),
    .rs2_o          (rf_raddr_b_o),
    .rd_o           (rd),
    .imm_o          (imm),
    .alu_op_o       (alu_op),
    .src_a_sel_o    (src_a_sel),
    .src_b_sel_o    (src_b_sel),
    .br_a_sel_o     (br_a_sel),
    .rf_we_o        (rf_we),
    .mem_rd_o       (mem_rd),
    .mem_wr_o       (mem_wr),
    .mem_sign_ext_o (mem_sign_ext),
    .mem_size_o     (mem_size)
);

// Registered destination and load flag describe the instruction in EX
rv_bypass_ctrl u_bypass_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .rs1_i         (rf_raddr_a_o),
    .rs2_i         (rf_raddr_b_o),
    .opcode_i      (opcode),
    .ex_we_i       (ex_we_i),
    .mem_we_i      (mem_we_i),
    .ex_rd_i       (ex_rd_i),
    .mem_rd_i      (mem_rd_i),
    .issued_rd_i   (rf_waddr_o),
    .issued_load_i (mem_rd_o),
    .bypass_a_o    (bypass_a),
    .bypass_b_o    (bypass_b),
    .load_use_o    (load_use_o)
);

always_comb begin : fwd_mux
    case (bypass_a)
        BYP_EX:  data_a = ex_data_i;
        BYP_MEM: data_a = mem_data_i;
        default: data_a = rf_data_a_i;
    endcase
    case (bypass_b)
        BYP_EX:  data_b = ex_data_i;
        BYP_MEM: data_b = mem_data_i;
        default: data_b = rf_data_b_i;
    endcase
end

always_comb begin : alu_a_mux
    case (src_a_sel)
        SRC_A_ZERO: alu_a = '0;
        SRC_A_PC:   alu_a = pc_i;
        default:    alu_a = data_a;
    endcase
end

assign alu_b = (src_b_sel == SRC_B_IMM) ? imm : data_b;
assign br_a  = (br_a_sel == BR_A_PC4) ? pc_i + word_t'(4) : data_a;

// Control half of ID/EX, also the issued-load record
always_ff @(posedge clk_i) begin : idex_ctrl
    if (!rst_n_i) begin
        rf_we_o    <= 1'b0;
        mem_rd_o   <= 1'b0;
        mem_wr_o   <= 1'b0;
        bypass_a_o <= BYP_NONE;
        bypass_b_o <= BYP_NONE;
    end else if (!hazard_i) begin
        rf_we_o    <= (instr_i == NOP_INSTR) ? 1'b0 : rf_we;
        mem_rd_o   <= mem_rd;
        mem_wr_o   <= mem_wr;
        bypass_a_o <= bypass_a;
        bypass_b_o <= bypass_b;
    end
end

always_ff @(posedge clk_i) begin : idex_data
    if (!hazard_i) begin
        alu_op_o       <= alu_op;
        alu_a_o        <= alu_a;
        alu_b_o        <= alu_b;
        rf_waddr_o     <= rd;
        mem_size_o     <= mem_size;
        mem_sign_ext_o <= mem_sign_ext;
        store_data_o   <= data_b;
        br_a_o         <= br_a;
        br_b_o         <= data_b;
    end
end

a_mem_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(mem_rd_o && mem_wr_o));

// Held stage presents the same bundle on the next cycle
a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    hazard_i |=> $stable({alu_op_o, alu_a_o, alu_b_o, rf_we_o, rf_waddr_o, mem_rd_o,
                          mem_wr_o, mem_size_o, mem_sign_ext_o, store_data_o,
                          br_a_o, br_b_o, bypass_a_o, bypass_b_o}));

endmodule

//--- id_stage/rv_bypass_ctrl.sv
`timescale 1ns/1ps

module rv_bypass_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  rv_isa_pkg::reg_addr_t rs1_i,
    input  rv_isa_pkg::reg_addr_t rs2_i,
    input  rv_isa_pkg::opcode_e   opcode_i,
    input  logic                  ex_we_i,
    input  logic                  mem_we_i,
    input  rv_isa_pkg::reg_addr_t ex_rd_i,
    input  rv_isa_pkg::reg_addr_t mem_rd_i,
    input  rv_isa_pkg::reg_addr_t issued_rd_i,
    input  logic                  issued_load_i,
    output rv_ctrl_pkg::bypass_e  bypass_a_o,
    output rv_ctrl_pkg::bypass_e  bypass_b_o,
    output logic                  load_use_o
);

import rv_isa_pkg::*;
import rv_ctrl_pkg::*;

reg_addr_t src_a;
reg_addr_t src_b;
logic      no_src;
logic      uses_a;
logic      uses_b;

// EX holds the newest value and wins over MEM
function automatic bypass_e pick_source(input reg_addr_t src);
    if (src == '0) begin
        return BYP_NONE;
    end
    if (ex_we_i && ex_rd_i == src) begin
        return BYP_EX;
    end
    if (mem_we_i && mem_rd_i == src) begin
        return BYP_MEM;
    end
    return BYP_NONE;
endfunction

// U-type fields overlap the source slots
assign no_src = (opcode_i == OPC_LUI) || (opcode_i == OPC_AUIPC);
assign src_a  = no_src ? '0 : rs1_i;
assign src_b  = no_src ? '0 : rs2_i;

assign uses_a = opcode_i inside {OPC_OP_IMM, OPC_OP, OPC_LOAD, OPC_STORE, OPC_BRANCH};
assign uses_b = opcode_i inside {OPC_OP, OPC_STORE, OPC_BRANCH};

always_comb begin : bypass_sel
    bypass_a_o = pick_source(src_a);
    bypass_b_o = pick_source(src_b);
end

// Load in EX has no data yet
assign load_use_o = issued_load_i && (issued_rd_i != '0) &&
                    ((uses_a && src_a == issued_rd_i) || (uses_b && src_b == issued_rd_i));

// Only a used nonzero source register can stall
a_load_use_src: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ((rs1_i == '0 || !uses_a) && (rs2_i == '0 || !uses_b)) |-> !load_use_o);

endmodule

//--- id_stage/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  rv_isa_pkg::word_t       instr_i,
    output rv_isa_pkg::opcode_e     opcode_o,
    output rv_isa_pkg::reg_addr_t   rs1_o,
    output rv_isa_pkg::reg_addr_t   rs2_o,
    output rv_isa_pkg::reg_addr_t   rd_o,
    output rv_isa_pkg::word_t       imm_o,
    output rv_ctrl_pkg::alu_op_e    alu_op_o,
    output rv_ctrl_pkg::src_a_sel_e src_a_sel_o,
    output rv_ctrl_pkg::src_b_sel_e src_b_sel_o,
    output rv_ctrl_pkg::br_a_sel_e  br_a_sel_o,
    output logic                    rf_we_o,
    output logic                    mem_rd_o,
    output logic                    mem_wr_o,
    output logic                    mem_sign_ext_o,
    output rv_ctrl_pkg::mem_size_e  mem_size_o
);

import rv_isa_pkg::*;
import rv_ctrl_pkg::*;

logic [2:0] funct3;
logic       funct7_b5;
alu_op_e    arith_op;
mem_size_e  acc_size;

assign funct3    = instr_i[14:12];
assign funct7_b5 = instr_i[30];

assign rs1_o = instr_i[19:15];
assign rs2_o = instr_i[24:20];
assign rd_o  = instr_i[11:7];

// Size 2'b11 is not defined for RV32, treat as word
assign acc_size = funct3[1] ? MEM_WORD : (funct3[0] ? MEM_HALF : MEM_BYTE);

always_comb begin : opcode_dec
    case (instr_i[6:0])
        OPC_LOAD, OPC_OP_IMM, OPC_AUIPC, OPC_STORE,
        OPC_OP, OPC_LUI, OPC_BRANCH, OPC_JAL: opcode_o = opcode_e'(instr_i[6:0]);
        default:                              opcode_o = OPC_INVALID;
    endcase
end

// Shared by OP and OP-IMM, SUB only exists in register form
always_comb begin : arith_dec
    case (funct3)
        3'b000:  arith_op = (opcode_o == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
        3'b001:  arith_op = ALU_SLL;
        3'b010:  arith_op = ALU_SLT;
        3'b011:  arith_op = ALU_SLTU;
        3'b100:  arith_op = ALU_XOR;
        3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
        3'b110:  arith_op = ALU_OR;
        default: arith_op = ALU_AND;
    endcase
end

always_comb begin : ctrl_dec
    imm_o          = '0;
    alu_op_o       = ALU_ADD;
    src_a_sel_o    = SRC_A_REG;
    src_b_sel_o    = SRC_B_IMM;
    br_a_sel_o     = BR_A_REG;
    rf_we_o        = 1'b0;
    mem_rd_o       = 1'b0;
    mem_wr_o       = 1'b0;
    mem_sign_ext_o = 1'b0;
    mem_size_o     = MEM_WORD;
    case (opcode_o)
        OPC_LUI: begin
            imm_o       = {instr_i[31:12], 12'b0};
            src_a_sel_o = SRC_A_ZERO;
            rf_we_o     = 1'b1;
        end
        OPC_AUIPC: begin
            imm_o       = {instr_i[31:12], 12'b0};
            src_a_sel_o = SRC_A_PC;
            rf_we_o     = 1'b1;
        end
        OPC_OP_IMM: begin
            imm_o    = {{20{instr_i[31]}}, instr_i[31:20]};
            alu_op_o = arith_op;
            rf_we_o  = 1'b1;
        end
        OPC_OP: begin
            src_b_sel_o = SRC_B_REG;
            alu_op_o    = arith_op;
            rf_we_o     = 1'b1;
        end
        OPC_LOAD: begin
            imm_o          = {{20{instr_i[31]}}, instr_i[31:20]};
            rf_we_o        = 1'b1;
            mem_rd_o       = 1'b1;
            mem_sign_ext_o = ~funct3[2];
            mem_size_o     = acc_size;
        end
        OPC_STORE: begin
            imm_o      = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            mem_wr_o   = 1'b1;
            mem_size_o = acc_size;
        end
        // ALU forms the target, operands compare through br_a and br_b
        OPC_BRANCH: begin
            imm_o       = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                           instr_i[30:25], instr_i[11:8], 1'b0};
            src_a_sel_o = SRC_A_PC;
        end
        OPC_JAL: begin
            imm_o       = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                           instr_i[20], instr_i[30:21], 1'b0};
            src_a_sel_o = SRC_A_PC;
            br_a_sel_o  = BR_A_PC4;
            rf_we_o     = 1'b1;
        end
        default: ;
    endcase
end

endmodule

//--- common/rv_ctrl_pkg.sv
package rv_ctrl_pkg;

// ALU operations, branch compare is done in EX
typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
} alu_op_e;

// ALU operand sources
typedef enum logic [1:0] {
    SRC_A_REG,
    SRC_A_ZERO,
    SRC_A_PC
} src_a_sel_e;

typedef enum logic {
    SRC_B_REG,
    SRC_B_IMM
} src_b_sel_e;

// Branch operand A, PC plus 4 is the JAL link value
typedef enum logic {
    BR_A_REG,
    BR_A_PC4
} br_a_sel_e;

// Encoded as funct3[1:0]
typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_HALF = 2'b01,
    MEM_WORD = 2'b10
} mem_size_e;

// Operand forwarding source
typedef enum logic [1:0] {
    BYP_NONE,
    BYP_EX,
    BYP_MEM
} bypass_e;

endpackage

//--- common/rv_isa_pkg.sv
`include "rv_config.svh"

package rv_isa_pkg;

// Data word and register index
typedef logic [`RV_WORD_W-1:0]     word_t;
typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

// Major opcodes handled by the decode stage
typedef enum logic [6:0] {
    OPC_INVALID = 7'b0000000,
    OPC_LOAD    = 7'b0000011,
    OPC_OP_IMM  = 7'b0010011,
    OPC_AUIPC   = 7'b0010111,
    OPC_STORE   = 7'b0100011,
    OPC_OP      = 7'b0110011,
    OPC_LUI     = 7'b0110111,
    OPC_BRANCH  = 7'b1100011,
    OPC_JAL     = 7'b1101111
} opcode_e;

// Bubble word, never writes back
localparam word_t NOP_INSTR = `RV_NOP;

endpackage

//--- common/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath width and register file geometry
`define RV_WORD_W     32
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS   32

// Canonical bubble, ADDI x0, x0, 0
`define RV_NOP        32'h0000_0013

`endif
